//--- design/game_loader.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Game loader
// Parses the iNES header, then writes PRG and CHR pages
// into the linear cartridge map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module game_loader #(
	parameter int PRG_PAGE_SHIFT = nes_cart_pkg::PRG_PAGE_SHIFT_DEFAULT,
	parameter int CHR_PAGE_SHIFT = nes_cart_pkg::CHR_PAGE_SHIFT_DEFAULT
) (
	input  logic                        clk,
	input  logic                        loader_reset,
	input  logic                        downloading,
	input  logic                        byte_strobe,
	input  nes_cart_pkg::cart_byte_t    byte_in,
	input  logic                        invert_mirroring,
	output nes_cart_pkg::mem_write_t    mem_wr,
	output nes_cart_pkg::mapper_flags_t cart_flags,
	output logic                        busy,
	output logic                        done,
	output logic                        error
);
	import nes_cart_pkg::*;

	loader_state_e state;
	logic [3:0]    hdr_cnt;       // Header byte index
	cart_addr_t    wr_addr;
	cart_addr_t    bytes_left;
	cart_addr_t    prg_bytes;
	cart_addr_t    chr_bytes;
	logic          hdr_we;
	logic          header_ok;
	cart_byte_t    prg_pages;
	cart_byte_t    chr_pages;
	mapper_flags_t hdr_flags;
	mapper_flags_t flags_q;
	logic          load_active;

	assign hdr_we = byte_strobe && (state == load_header);

	ines_header_decoder u_header (
		.clk              (clk),
		.hdr_we           (hdr_we),
		.hdr_index        (hdr_cnt),
		.hdr_byte         (byte_in),
		.invert_mirroring (invert_mirroring),
		.header_ok        (header_ok),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.flags            (hdr_flags)
	);

	assign prg_bytes = cart_addr_t'(prg_pages) << PRG_PAGE_SHIFT;
	assign chr_bytes = cart_addr_t'(chr_pages) << CHR_PAGE_SHIFT;

	assign load_active = ((state == load_prg) || (state == load_chr)) && (bytes_left != '0);

	// Write goes out in the strobe cycle itself
	assign mem_wr.addr = wr_addr;
	assign mem_wr.data = byte_in;
	assign mem_wr.we   = load_active && byte_strobe;

	always_ff @(posedge clk) begin
		if (loader_reset) begin
			state      <= load_header;
			hdr_cnt    <= 4'd0;
			wr_addr    <= '0;
			bytes_left <= '0;
			busy       <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
		end else begin
			case (state)
				load_header: begin
					if (byte_strobe) begin
						hdr_cnt <= hdr_cnt + 4'd1;
						if (hdr_cnt == 4'd15) begin
							if (header_ok) begin
								state      <= load_prg;
								busy       <= 1'b1;
								wr_addr    <= '0;           // PRG at the bottom
								bytes_left <= prg_bytes;
							end else begin
								state <= load_error;        // Bad magic or trainer
							end
						end
					end
				end
				load_prg, load_chr: begin
					if (bytes_left != '0) begin
						if (byte_strobe) begin
							bytes_left <= bytes_left - 1'b1;
							wr_addr    <= wr_addr + 1'b1;
						end
					end else if (state == load_prg && chr_pages != 8'd0) begin
						state      <= load_chr;
						wr_addr    <= CHR_BASE;
						bytes_left <= chr_bytes;
					end else begin
						// CHR RAM carts have nothing after PRG
						state <= load_done;
						done  <= 1'b1;
						busy  <= 1'b0;
					end
				end
				load_error: begin
					done  <= 1'b1;
					error <= 1'b1;
					busy  <= 1'b0;
				end
				load_done: begin
					done <= 1'b1;
				end
				default: state <= load_header;
			endcase
		end
	end

	// Flags held for the console once the image is in
	always_ff @(posedge clk) begin
		if (done)
			flags_q <= hdr_flags;
	end

	assign cart_flags = downloading ? '0 : flags_q;

endmodule

//--- design/ines_header_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// iNES header decoder
// Holds the 16 header bytes, checks magic and trainer bit,
// and builds the mapper flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ines_header_decoder (
	input  logic                        clk,
	input  logic                        hdr_we,
	input  logic [3:0]                  hdr_index,
	input  nes_cart_pkg::cart_byte_t    hdr_byte,
	input  logic                        invert_mirroring,
	output logic                        header_ok,
	output nes_cart_pkg::cart_byte_t    prg_pages,
	output nes_cart_pkg::cart_byte_t    chr_pages,
	output nes_cart_pkg::mapper_flags_t flags
);
	import nes_cart_pkg::*;

	cart_byte_t hdr [16];
	logic       is_nes20;
	logic       is_dirty;
	logic       has_trainer;

	// Page count to size class, <=1 is 0 and >64 is 7
	function automatic logic [2:0] size_class(input cart_byte_t pages);
		if (pages <= 8'd1)
			return 3'd0;
		else if (pages <= 8'd2)
			return 3'd1;
		else if (pages <= 8'd4)
			return 3'd2;
		else if (pages <= 8'd8)
			return 3'd3;
		else if (pages <= 8'd16)
			return 3'd4;
		else if (pages <= 8'd32)
			return 3'd5;
		else if (pages <= 8'd64)
			return 3'd6;
		else
			return 3'd7;
	endfunction

	always_ff @(posedge clk) begin
		if (hdr_we)
			hdr[hdr_index] <= hdr_byte;
	end

	assign prg_pages   = hdr[4];
	assign chr_pages   = hdr[5];
	assign has_trainer = hdr[6][2];
	assign header_ok   = ({hdr[0], hdr[1], hdr[2], hdr[3]} == INES_MAGIC) && !has_trainer;

	assign is_nes20 = (hdr[7][3:2] == 2'b10);

	// Old rippers left junk in the tail of the header
	assign is_dirty = !is_nes20 && ((hdr[9][7:1] != 7'd0) ||
		(|{hdr[10], hdr[11], hdr[12], hdr[13], hdr[14], hdr[15]}));

	assign flags.has_saves    = hdr[6][1];
	assign flags.ines2_mapper = is_nes20 ? hdr[8] : 8'h00;
	assign flags.four_screen  = hdr[6][3];
	assign flags.has_chr_ram  = (chr_pages == 8'd0);
	assign flags.mirroring    = hdr[6][0] ^ invert_mirroring;
	assign flags.chr_size     = size_class(chr_pages);
	assign flags.prg_size     = size_class(prg_pages);
	assign flags.mapper       = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};  // Upper nibble in byte 7

endmodule

//--- design/joypad_serializer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Joypad serializer
// Two NES controller ports with swap and four-player tap
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module joypad_serializer (
	input  logic                       clk,
	input  logic                       reset_nes,
	input  nes_cart_pkg::pad_buttons_t joy_a,
	input  nes_cart_pkg::pad_buttons_t joy_b,
	input  nes_cart_pkg::pad_buttons_t joy_c,
	input  nes_cart_pkg::pad_buttons_t joy_d,
	input  logic                       joy_swap,
	input  logic                       multitap,
	input  logic                       joypad_strobe,
	input  logic [1:0]                 joypad_clock,
	output logic [1:0]                 joypad_data
);
	import nes_cart_pkg::*;

	logic [23:0] shift_q [2];
	logic [23:0] load_val [2];
	logic [1:0]  clock_q;     // Previous joypad_clock for edge detect

	// NES order from bit 0 up is A, B, Select, Start, Up, Down, Left, Right
	function automatic cart_byte_t nes_order(input pad_buttons_t pad);
		return {pad.right, pad.left, pad.down, pad.up, pad.start, pad.select, pad.b, pad.a};
	endfunction

	assign load_val[0] = {multitap ? {MULTITAP_SIG_1, nes_order(joy_c)} : 16'hFFFF,
		nes_order(joy_swap ? joy_b : joy_a)};
	assign load_val[1] = {multitap ? {MULTITAP_SIG_2, nes_order(joy_d)} : 16'hFFFF,
		nes_order(joy_swap ? joy_a : joy_b)};

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			shift_q[0] <= '0;
			shift_q[1] <= '0;
			clock_q    <= 2'b00;
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (joypad_strobe)
					shift_q[p] <= load_val[p];
				// Falling clock edge moves to the next button
				if (!joypad_clock[p] && clock_q[p])
					shift_q[p] <= {1'b0, shift_q[p][23:1]};
			end
			clock_q <= joypad_clock;
		end
	end

	assign joypad_data = {shift_q[1][0], shift_q[0][0]};

endmodule

//--- design/nes_cart_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NES cartridge front end shared definitions
// Loader states, iNES flag layout, memory write bus, pad bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package nes_cart_pkg;

	typedef logic [21:0] cart_addr_t;   // Linear cartridge address
	typedef logic [7:0]  cart_byte_t;

	// Game loader FSM
	typedef enum logic [2:0] {
		load_header,
		load_prg,
		load_chr,
		load_error,
		load_done
	} loader_state_e;

	// Mapper flags as seen by the console core
	typedef struct packed {
		logic       has_saves;
		logic [7:0] ines2_mapper;  // Byte 8 on iNES 2.0 only
		logic       four_screen;
		logic       has_chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;      // Power-of-two size class
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	typedef struct packed {
		cart_addr_t addr;
		cart_byte_t data;
		logic       we;
	} mem_write_t;

	// Host button order
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic a;
		logic b;
		logic select;
		logic start;
	} pad_buttons_t;

	localparam cart_addr_t  CHR_BASE        = 22'h20_0000;
	localparam logic [31:0] INES_MAGIC      = {8'h4E, 8'h45, 8'h53, 8'h1A};  // "NES" EOF
	localparam cart_byte_t  MULTITAP_SIG_1  = 8'h08;
	localparam cart_byte_t  MULTITAP_SIG_2  = 8'h04;
	localparam logic [7:0]  DL_RESET_CYCLES = 8'd255;

	// Defaults for the page size parameters of the top level
	localparam int PRG_PAGE_SHIFT_DEFAULT = 14;  // 16 KiB pages
	localparam int CHR_PAGE_SHIFT_DEFAULT = 13;  // 8 KiB pages

endpackage

//--- design/nes_loader_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NES cartridge front end top level
// Game loader, reset sequencer and joypad ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module nes_loader_top #(
	parameter int PRG_PAGE_SHIFT = nes_cart_pkg::PRG_PAGE_SHIFT_DEFAULT,
	parameter int CHR_PAGE_SHIFT = nes_cart_pkg::CHR_PAGE_SHIFT_DEFAULT
) (
	input  logic                        clk,
	input  logic                        reset_nes,
	input  logic                        downloading,
	input  logic                        byte_strobe,
	input  nes_cart_pkg::cart_byte_t    byte_in,
	input  logic                        invert_mirroring,
	input  nes_cart_pkg::pad_buttons_t  joy_a,
	input  nes_cart_pkg::pad_buttons_t  joy_b,
	input  nes_cart_pkg::pad_buttons_t  joy_c,
	input  nes_cart_pkg::pad_buttons_t  joy_d,
	input  logic                        joy_swap,
	input  logic                        multitap,
	input  logic                        joypad_strobe,
	input  logic [1:0]                  joypad_clock,
	output nes_cart_pkg::mem_write_t    mem_wr,
	output nes_cart_pkg::mapper_flags_t cart_flags,
	output logic                        loader_busy,
	output logic                        loader_done,
	output logic                        loader_error,
	output logic                        console_reset,
	output logic [1:0]                  joypad_data
);

	logic loader_reset;  // Restarts the loader between files

	game_loader #(
		.PRG_PAGE_SHIFT (PRG_PAGE_SHIFT),
		.CHR_PAGE_SHIFT (CHR_PAGE_SHIFT)
	) u_loader (
		.clk              (clk),
		.loader_reset     (loader_reset),
		.downloading      (downloading),
		.byte_strobe      (byte_strobe),
		.byte_in          (byte_in),
		.invert_mirroring (invert_mirroring),
		.mem_wr           (mem_wr),
		.cart_flags       (cart_flags),
		.busy             (loader_busy),
		.done             (loader_done),
		.error            (loader_error)
	);

	reset_sequencer u_reset_seq (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.downloading   (downloading),
		.loader_busy   (loader_busy),
		.loader_error  (loader_error),
		.loader_reset  (loader_reset),
		.console_reset (console_reset)
	);

	joypad_serializer u_joypad (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.joy_a         (joy_a),
		.joy_b         (joy_b),
		.joy_c         (joy_c),
		.joy_d         (joy_d),
		.joy_swap      (joy_swap),
		.multitap      (multitap),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock),
		.joypad_data   (joypad_data)
	);

endmodule

//--- design/reset_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Console reset sequencer
// Holds reset until the first download, then for a fixed
// time after each download or while the image is bad
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module reset_sequencer (
	input  logic clk,
	input  logic reset_nes,
	input  logic downloading,
	input  logic loader_busy,
	input  logic loader_error,
	output logic loader_reset,
	output logic console_reset
);
	import nes_cart_pkg::*;

	logic       init_done;   // Set once a file has been seen
	logic [7:0] dl_cnt;
	logic       dl_active;

	assign dl_active = (dl_cnt != 8'd0);

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			init_done <= 1'b0;
			dl_cnt    <= 8'd0;
		end else begin
			if (downloading)
				init_done <= 1'b1;

			// Countdown freezes while the loader works or has failed
			if (downloading)
				dl_cnt <= DL_RESET_CYCLES;
			else if (dl_active && !loader_busy && !loader_error)
				dl_cnt <= dl_cnt - 8'd1;
		end
	end

	assign loader_reset  = !dl_active && !downloading;  // Loader idles between files
	assign console_reset = !init_done || downloading || dl_active || loader_error;

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the NES loader testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module nes_loader_tb -o nes_loader_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/nes_loader_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
	echo "Test failed, see $LOG"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
echo "Test passed"
exit 0

//--- sim/nes_loader_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NES cartridge front end testbench
// Streams iNES images from a header table and checks writes,
// flags, console reset timing and the two joypad ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module nes_loader_tb;
	import nes_cart_pkg::*;

	localparam int          PRG_SHIFT     = 4;   // 16-byte PRG pages
	localparam int          CHR_SHIFT     = 3;   // 8-byte CHR pages
	localparam int          NUM_ROWS      = 7;
	localparam int          DL_CYCLES     = 255;
	localparam int          DONE_WAIT     = 50;
	localparam logic [31:0] SEED          = 32'h0da9_e2f5;
	localparam logic [31:0] MAGIC         = 32'h4E45_531A;
	localparam logic [31:0] BAD_MAGIC     = 32'h4E45_531B;
	localparam cart_addr_t  CHR_START     = 22'h20_0000;
	localparam logic [7:0]  TAP_SIG_PORT0 = 8'h08;
	localparam logic [7:0]  TAP_SIG_PORT1 = 8'h04;
	// Host bit index for each NES button slot, A first
	localparam int          NES_FROM_HOST [8] = '{3, 2, 1, 0, 4, 5, 6, 7};

	typedef struct packed {
		logic [127:0]  hdr;    // Byte 0 in the top bits
		logic          inv;
		mapper_flags_t flags;
		logic          err;
	} row_t;

	logic          clk;
	logic          reset_nes;
	logic          downloading;
	logic          byte_strobe;
	cart_byte_t    byte_in;
	logic          invert_mirroring;
	pad_buttons_t  joy_a;
	pad_buttons_t  joy_b;
	pad_buttons_t  joy_c;
	pad_buttons_t  joy_d;
	logic          joy_swap;
	logic          multitap;
	logic          joypad_strobe;
	logic [1:0]    joypad_clock;
	mem_write_t    mem_wr;
	mapper_flags_t cart_flags;
	logic          loader_busy;
	logic          loader_done;
	logic          loader_error;
	logic          console_reset;
	logic [1:0]    joypad_data;

	row_t        rows [NUM_ROWS];
	logic [29:0] sent_q[$];   // Model memory, addr and data in send order
	logic [29:0] seen_q[$];

	nes_loader_top #(
		.PRG_PAGE_SHIFT (PRG_SHIFT),
		.CHR_PAGE_SHIFT (CHR_SHIFT)
	) DUT (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.downloading      (downloading),
		.byte_strobe      (byte_strobe),
		.byte_in          (byte_in),
		.invert_mirroring (invert_mirroring),
		.joy_a            (joy_a),
		.joy_b            (joy_b),
		.joy_c            (joy_c),
		.joy_d            (joy_d),
		.joy_swap         (joy_swap),
		.multitap         (multitap),
		.joypad_strobe    (joypad_strobe),
		.joypad_clock     (joypad_clock),
		.mem_wr           (mem_wr),
		.cart_flags       (cart_flags),
		.loader_busy      (loader_busy),
		.loader_done      (loader_done),
		.loader_error     (loader_error),
		.console_reset    (console_reset),
		.joypad_data      (joypad_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped");
	endtask

	task automatic value_error(input string msg);
		$display("error at %0t: %s", $time, msg);
		abort_run();
	endtask

	function automatic logic [127:0] header_bytes(input logic [31:0] magic,
			input logic [7:0] prg, input logic [7:0] chr, input logic [7:0] f6,
			input logic [7:0] f7, input logic [7:0] b8, input logic [55:0] tail);
		return {magic, prg, chr, f6, f7, b8, tail};   // Tail is bytes 9 to 15
	endfunction

	function automatic mapper_flags_t expect_flags(input logic saves, input logic [7:0] i2,
			input logic four, input logic chr_ram, input logic mirr,
			input logic [2:0] chr_sz, input logic [2:0] prg_sz, input logic [7:0] mapper);
		mapper_flags_t f;
		f.has_saves    = saves;
		f.ines2_mapper = i2;
		f.four_screen  = four;
		f.has_chr_ram  = chr_ram;
		f.mirroring    = mirr;
		f.chr_size     = chr_sz;
		f.prg_size     = prg_sz;
		f.mapper       = mapper;
		return f;
	endfunction

	function automatic logic [7:0] row_byte(input int r, input int idx);
		return rows[r].hdr[127 - 8 * idx -: 8];
	endfunction

	function automatic int row_bytes(input int r);
		return 16 + (int'(row_byte(r, 4)) << PRG_SHIFT) + (int'(row_byte(r, 5)) << CHR_SHIFT);
	endfunction

	function automatic logic [7:0] nes_bits(input pad_buttons_t pad);
		logic [7:0] host;
		logic [7:0] r;
		host = pad;
		for (int i = 0; i < 8; i++)
			r[i] = host[NES_FROM_HOST[i]];
		return r;
	endfunction

	// 24 bits a port shifts out, bit 0 first
	function automatic logic [23:0] port_stream(input pad_buttons_t main_pad,
			input pad_buttons_t tap_pad, input logic tap, input logic [7:0] sig);
		logic [23:0] s;
		s = '1;
		s[7:0] = nes_bits(main_pad);
		if (tap) begin
			s[15:8]  = nes_bits(tap_pad);
			s[23:16] = sig;
		end
		return s;
	endfunction

	task automatic build_table();
		rows[0] = '{header_bytes(MAGIC, 8'd2, 8'd1, 8'h11, 8'h00, 8'h00, 56'h0), 1'b0,
			expect_flags(1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 3'd0, 3'd1, 8'h01), 1'b0};
		// Junk in byte 12 clears the upper mapper nibble
		rows[1] = '{header_bytes(MAGIC, 8'd1, 8'd2, 8'h42, 8'h30, 8'h00, 56'h00000055000000),
			1'b0, expect_flags(1'b1, 8'h00, 1'b0, 1'b0, 1'b0, 3'd1, 3'd0, 8'h04), 1'b0};
		rows[2] = '{header_bytes(MAGIC, 8'd3, 8'd1, 8'h18, 8'h48, 8'h21, 56'h00070000000000),
			1'b0, expect_flags(1'b0, 8'h21, 1'b1, 1'b0, 1'b0, 3'd0, 3'd2, 8'h41), 1'b0};
		rows[3] = '{header_bytes(MAGIC, 8'd1, 8'd1, 8'h01, 8'h10, 8'h00, 56'h0), 1'b1,
			expect_flags(1'b0, 8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 3'd0, 8'h10), 1'b0};
		rows[4] = '{header_bytes(MAGIC, 8'd2, 8'd0, 8'h20, 8'h00, 8'h00, 56'h0), 1'b1,
			expect_flags(1'b0, 8'h00, 1'b0, 1'b1, 1'b1, 3'd0, 3'd1, 8'h02), 1'b0};
		rows[5] = '{header_bytes(BAD_MAGIC, 8'd1, 8'd1, 8'h00, 8'h00, 8'h00, 56'h0), 1'b0,
			'0, 1'b1};
		rows[6] = '{header_bytes(MAGIC, 8'd1, 8'd1, 8'h04, 8'h00, 8'h00, 56'h0), 1'b0,
			'0, 1'b1};   // Trainer bit set
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset_nes <= 1'b1;
		repeat (10) @(posedge clk);
		reset_nes <= 1'b0;
	endtask

	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			assert (console_reset && !loader_busy && !loader_done && !loader_error && !mem_wr.we)
			else value_error("outputs not idle with console held in reset");
		end
	endtask

	// One strobe cycle followed by one idle cycle
	task automatic send_byte(input cart_byte_t b);
		@(posedge clk);
		byte_strobe <= 1'b1;
		byte_in     <= b;
		@(posedge clk);
		byte_strobe <= 1'b0;
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		@(negedge clk);
		while (!loader_done && n < DONE_WAIT) begin
			n++;
			@(negedge clk);
		end
		assert (loader_done) else value_error("loader_done did not rise after the last byte");
	endtask

	task automatic run_row(input int r);
		cart_byte_t pay;
		int         prg_n;
		int         chr_n;
		int         high_cycles;
		@(posedge clk);
		sent_q.delete();
		seen_q.delete();
		downloading      <= 1'b1;
		invert_mirroring <= rows[r].inv;
		@(negedge clk);
		assert (cart_flags == '0) else value_error("cart_flags not zero while downloading");
		for (int i = 0; i < 16; i++)
			send_byte(row_byte(r, i));
		prg_n = int'(row_byte(r, 4)) << PRG_SHIFT;
		chr_n = int'(row_byte(r, 5)) << CHR_SHIFT;
		for (int i = 0; i < prg_n; i++) begin
			pay = 8'($urandom());
			if (!rows[r].err)
				sent_q.push_back({cart_addr_t'(i), pay});
			send_byte(pay);
		end
		for (int i = 0; i < chr_n; i++) begin
			pay = 8'($urandom());
			if (!rows[r].err)
				sent_q.push_back({CHR_START + cart_addr_t'(i), pay});
			send_byte(pay);
		end
		if (!rows[r].err) begin
			@(negedge clk);   // Last byte just taken, done comes on the next edge
			assert (loader_busy && !loader_done)
			else value_error($sformatf("row %0d busy %0b done %0b before the load ended",
				r, loader_busy, loader_done));
		end
		wait_done();
		assert (loader_error == rows[r].err)
		else value_error($sformatf("row %0d loader_error is %0b", r, loader_error));
		assert (seen_q.size() == sent_q.size())
		else value_error($sformatf("row %0d has %0d writes, expected %0d",
			r, seen_q.size(), sent_q.size()));
		foreach (sent_q[k]) begin
			assert (seen_q[k] == sent_q[k])
			else value_error($sformatf("row %0d write %0d at %h data %h, expected %h data %h",
				r, k, seen_q[k][29:8], seen_q[k][7:0], sent_q[k][29:8], sent_q[k][7:0]));
		end
		@(posedge clk);
		downloading <= 1'b0;
		if (rows[r].err) begin
			repeat (20) begin
				@(negedge clk);
				assert (console_reset && loader_error)
				else value_error("console_reset released after a bad image");
			end
		end else begin
			@(negedge clk);
			assert (cart_flags == rows[r].flags)
			else value_error($sformatf("row %0d cart_flags %h, expected %h",
				r, cart_flags, rows[r].flags));
			high_cycles = 0;
			while (console_reset && high_cycles < 2 * DL_CYCLES) begin
				high_cycles++;
				@(negedge clk);
			end
			assert (high_cycles >= DL_CYCLES && !console_reset)
			else value_error($sformatf("console_reset high for %0d cycles after download",
				high_cycles));
		end
	endtask

	task automatic run_pad_test(input logic swap, input logic tap);
		pad_buttons_t pa;
		pad_buttons_t pb;
		pad_buttons_t pc;
		pad_buttons_t pd;
		logic [23:0]  exp0;
		logic [23:0]  exp1;
		pa   = pad_buttons_t'(8'($urandom()));
		pb   = pad_buttons_t'(8'($urandom()));
		pc   = pad_buttons_t'(8'($urandom()));
		pd   = pad_buttons_t'(8'($urandom()));
		exp0 = port_stream(swap ? pb : pa, pc, tap, TAP_SIG_PORT0);
		exp1 = port_stream(swap ? pa : pb, pd, tap, TAP_SIG_PORT1);
		@(posedge clk);
		joy_a         <= pa;
		joy_b         <= pb;
		joy_c         <= pc;
		joy_d         <= pd;
		joy_swap      <= swap;
		multitap      <= tap;
		joypad_strobe <= 1'b1;
		@(posedge clk);
		joypad_strobe <= 1'b0;
		for (int i = 0; i < 24; i++) begin
			@(negedge clk);
			assert (joypad_data == {exp1[i], exp0[i]})
			else value_error($sformatf("pad bit %0d is %b, expected %b (swap %0b, tap %0b)",
				i, joypad_data, {exp1[i], exp0[i]}, swap, tap));
			@(posedge clk);
			joypad_clock <= 2'b11;
			@(posedge clk);
			joypad_clock <= 2'b00;
			@(posedge clk);   // Shift seen here through the registered clock
		end
		@(negedge clk);
		assert (joypad_data == 2'b00) else value_error("pad data not zero after 24 shifts");
	endtask

	// Every write the loader puts on the memory bus
	always @(negedge clk) begin
		if (mem_wr.we === 1'b1)
			seen_q.push_back({mem_wr.addr, mem_wr.data});
	end

	initial begin
		int total;
		int limit;
		@(posedge clk);
		total = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			total += row_bytes(r);
		limit = total * 4 + 2000;
		repeat (limit) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the test did not finish", limit);
		abort_run();
	end

	initial begin
		void'($urandom(SEED));
		reset_nes        = 1'b1;
		downloading      = 1'b0;
		byte_strobe      = 1'b0;
		byte_in          = '0;
		invert_mirroring = 1'b0;
		joy_a            = '0;
		joy_b            = '0;
		joy_c            = '0;
		joy_d            = '0;
		joy_swap         = 1'b0;
		multitap         = 1'b0;
		joypad_strobe    = 1'b0;
		joypad_clock     = 2'b00;
		build_table();
		for (int r = 0; r < NUM_ROWS; r++) begin
			apply_reset();   // Also clears a loader stuck in error
			check_idle(8);
			run_row(r);
		end
		run_pad_test(1'b0, 1'b0);
		run_pad_test(1'b1, 1'b0);
		run_pad_test(1'b0, 1'b1);
		run_pad_test(1'b1, 1'b1);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- verilog.f
design/nes_cart_pkg.sv
design/ines_header_decoder.sv
design/game_loader.sv
design/reset_sequencer.sv
design/joypad_serializer.sv
design/nes_loader_top.sv
sim/nes_loader_tb.sv
